//--- spidergon_pkg.sv
// shared flit format; NUM_NODES up to 8 (3-bit node ids) and exactly two virtual channels per port
`default_nettype none

package spidergon_pkg;

	localparam int FLIT_DATA_WIDTH = 16; // data field of every flit
	localparam int NODE_ID_WIDTH = 3; // dest and src fields in a head flit
	localparam int NUM_VCS = 2; // virtual channels per input port
	localparam int VC_WIDTH = 1; // vc tag carried in each flit
	localparam int NUM_RING_PORTS = 3; // anticlockwise, clockwise, across
	localparam int HEAD_PAYLOAD_WIDTH = 10; // what is left after dest and src

	// two-bit flit type at the top of the flit
	typedef enum logic [1:0]
	{
		TAIL_FLIT = 2'b00, // closes a packet
		HEAD_FLIT = 2'b01, // opens a packet
		BODY_FLIT = 2'b10, // middle of a packet
		HEADER = 2'b11 // whole packet in one flit
	} flit_type_t;

	// output direction, also the index into the ring output arrays
	typedef enum logic [1:0]
	{
		ANTI_CLOCKWISE = 2'd0,
		CLOCKWISE = 2'd1,
		ACROSS = 2'd2,
		STOP = 2'd3 // eject to the local cpu
	} dir_t;

	// layout of the data field in head flits and headers
	typedef struct packed
	{
		logic [NODE_ID_WIDTH-1:0] dest; // target node
		logic [NODE_ID_WIDTH-1:0] src; // sending node
		logic [HEAD_PAYLOAD_WIDTH-1:0] payload;
	} head_view_t;

	// head and header flits read the head view, body and tail flits the body view
	typedef union packed
	{
		head_view_t head;
		logic [FLIT_DATA_WIDTH-1:0] body; // full 16-bit payload
	} flit_data_u;

	// one flit, 19 bits
	typedef struct packed
	{
		flit_type_t ftype;
		logic [VC_WIDTH-1:0] vc; // upstream channel tag, rewritten on the way out
		flit_data_u data;
	} flit_t;

	// one flit with its strobe on a link
	typedef struct packed
	{
		logic valid;
		flit_t flit;
	} link_t;

endpackage

`default_nettype wire

//--- flit_fifo.sv
// one channel buffer; caller must not enqueue when full nor dequeue when empty, head_flit is stale when empty
`default_nettype none
`timescale 1ns/10ps

module flit_fifo
#(
	parameter int FIFO_DEPTH = 2
)
(
	input wire clk,
	input wire reset,
	input wire enqueue_en,
	input wire spidergon_pkg::flit_t enqueue_flit,
	input wire dequeue_en,
	output spidergon_pkg::flit_t head_flit,
	output logic empty,
	output logic full
);
	import spidergon_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	flit_t mem [FIFO_DEPTH]; // storage, no reset
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // flits held

	// circular increment, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (enqueue_en)
			mem[wr_ptr] <= enqueue_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (enqueue_en)
				wr_ptr <= ptr_next(wr_ptr);
			if (dequeue_en)
				rd_ptr <= ptr_next(rd_ptr);
			if (enqueue_en && !dequeue_en)
				count <= count + 1'b1;
			else if (dequeue_en && !enqueue_en)
				count <= count - 1'b1; // both at once keeps the count
		end
	end

	assign head_flit = mem[rd_ptr]; // oldest entry
	assign empty = (count == '0);
	assign full = (count == CNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- rr_arbiter.sv
// one-hot grant among req, starting at a rotating pointer; the pointer only moves when advance is high
`default_nettype none
`timescale 1ns/10ps

module rr_arbiter
#(
	parameter int WIDTH = 4
)
(
	input wire clk,
	input wire reset,
	input wire [WIDTH-1:0] req,
	input wire advance,
	output logic [WIDTH-1:0] grant
);
	localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

	logic [PTR_W-1:0] ptr; // highest priority requester
	logic [PTR_W-1:0] grant_idx; // binary form of grant

	// scan from ptr around the ring, first requester wins
	always_comb
	begin
		int idx;
		logic found;
		grant = '0;
		grant_idx = ptr;
		found = 1'b0;
		for (int i = 0; i < WIDTH; i++)
		begin
			idx = int'(ptr) + i;
			if (idx >= WIDTH)
				idx = idx - WIDTH; // wrap
			if (!found && req[idx])
			begin
				found = 1'b1;
				grant[idx] = 1'b1;
				grant_idx = PTR_W'(idx);
			end
		end
	end

	// winner drops to lowest priority
	always_ff @(posedge clk)
	begin
		if (reset)
			ptr <= '0;
		else if (advance && |grant)
			ptr <= (grant_idx == PTR_W'(WIDTH - 1)) ? '0 : grant_idx + 1'b1;
	end

endmodule

`default_nettype wire

//--- vc_alloc_fsm.sv
// upstream must keep its vc tags unique per open packet; port_ready needs a free channel, so keep one tag idle
`default_nettype none
`timescale 1ns/10ps

module vc_alloc_fsm
#(
	parameter int FIFO_DEPTH = 2
)
(
	input wire clk,
	input wire reset,
	input wire spidergon_pkg::link_t link,
	input wire [spidergon_pkg::NUM_VCS-1:0] fifo_full,
	output logic [spidergon_pkg::NUM_VCS-1:0] enqueue_en,
	output logic port_ready
);
	import spidergon_pkg::*;

	logic [NUM_VCS-1:0] reserved; // 0 idle, 1 reserved by an open packet
	logic [VC_WIDTH-1:0] tag [NUM_VCS]; // upstream vc of the packet holding the channel
	logic [NUM_VCS-1:0] free_req; // idle channels that can take one more flit
	logic [NUM_VCS-1:0] free_grant; // the one a new packet goes to
	logic opens; // head flit or header on the link
	logic is_head;
	logic is_tail;

	assign is_head = (link.flit.ftype == HEAD_FLIT);
	assign is_tail = (link.flit.ftype == TAIL_FLIT);
	assign opens = is_head || (link.flit.ftype == HEADER);

	// a free channel may still drain an older packet, hence the full check
	assign free_req = ~reserved & ~fifo_full;

	rr_arbiter #(.WIDTH(NUM_VCS)) free_arb_i
	(
		.clk(clk),
		.reset(reset),
		.req(free_req),
		.advance(link.valid && opens), // rotate only when a packet actually takes a channel
		.grant(free_grant)
	);

	// steer the incoming flit to exactly one fifo
	always_comb
	begin
		for (int v = 0; v < NUM_VCS; v++)
		begin
			if (opens)
				enqueue_en[v] = link.valid && free_grant[v];
			else
				enqueue_en[v] = link.valid && reserved[v] && (tag[v] == link.flit.vc); // follow the tag
		end
	end

	// reserve on head, release on tail; a header passes through without holding the channel
	always_ff @(posedge clk)
	begin
		if (reset)
			reserved <= '0;
		else
		begin
			for (int v = 0; v < NUM_VCS; v++)
			begin
				if (enqueue_en[v] && is_head)
					reserved[v] <= 1'b1;
				else if (enqueue_en[v] && is_tail)
					reserved[v] <= 1'b0;
			end
		end
	end

	// tag is payload of the reservation, only meaningful while reserved
	always_ff @(posedge clk)
	begin
		for (int v = 0; v < NUM_VCS; v++)
		begin
			if (enqueue_en[v] && is_head)
				tag[v] <= link.flit.vc;
		end
	end

	// a full fifo is known a cycle after its last enqueue, so FIFO_DEPTH of 1 still holds
	assign port_ready = (|free_req) && !(|(reserved & fifo_full));

endmodule

`default_nettype wire

//--- route_compute.sv
// needs NODE_ID < NUM_NODES <= 8; a channel fifo must start every packet with a head flit or header
`default_nettype none
`timescale 1ns/10ps

module route_compute
#(
	parameter int NODE_ID = 0,
	parameter int NUM_NODES = 8
)
(
	input wire clk,
	input wire reset,
	input wire spidergon_pkg::flit_t head_flit,
	input wire empty,
	input wire dequeue_en,
	output logic request,
	output spidergon_pkg::dir_t route
);
	import spidergon_pkg::*;

	localparam int REL_W = NODE_ID_WIDTH + 1; // spare bit for dest + offset before wrap
	localparam int QUARTER = NUM_NODES / 4;
	localparam int THREE_QUARTER = (3 * NUM_NODES) / 4;

	logic [REL_W-1:0] rel; // (dest - NODE_ID) mod NUM_NODES
	dir_t dir_now; // decision for the flit now at the fifo head
	dir_t route_q;
	logic route_valid; // a packet is open on this channel
	logic opens;
	logic closes;

	assign opens = (head_flit.ftype == HEAD_FLIT) || (head_flit.ftype == HEADER);
	assign closes = (head_flit.ftype == TAIL_FLIT) || (head_flit.ftype == HEADER);

	// spidergon rule on the head view
	always_comb
	begin
		rel = REL_W'(head_flit.data.head.dest) + REL_W'(NUM_NODES - NODE_ID);
		if (rel >= REL_W'(NUM_NODES))
			rel = rel - REL_W'(NUM_NODES);
		if (rel == '0)
			dir_now = STOP; // arrived
		else if (rel <= REL_W'(QUARTER))
			dir_now = CLOCKWISE;
		else if (rel >= REL_W'(THREE_QUARTER))
			dir_now = ANTI_CLOCKWISE;
		else
			dir_now = ACROSS; // far half of the ring
	end

	// latch at the packet head, hold for body flits, drop when the last flit leaves
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			route_valid <= 1'b0;
			route_q <= ANTI_CLOCKWISE;
		end
		else if (!route_valid && !empty && opens)
		begin
			route_valid <= 1'b1;
			route_q <= dir_now;
		end
		else if (dequeue_en && closes)
			route_valid <= 1'b0;
	end

	assign request = route_valid && !empty;
	assign route = route_q;

endmodule

`default_nettype wire

//--- switch_alloc.sv
// one flit per output per cycle; ring outputs send only while downstream_ready is high, cpu output never stalls
`default_nettype none
`timescale 1ns/10ps

module switch_alloc
(
	input wire clk,
	input wire reset,
	input wire spidergon_pkg::flit_t head_flit [spidergon_pkg::NUM_RING_PORTS*spidergon_pkg::NUM_VCS],
	input wire [spidergon_pkg::NUM_RING_PORTS*spidergon_pkg::NUM_VCS-1:0] request,
	input wire spidergon_pkg::dir_t route [spidergon_pkg::NUM_RING_PORTS*spidergon_pkg::NUM_VCS],
	input wire [spidergon_pkg::NUM_RING_PORTS-1:0] downstream_ready,
	output logic [spidergon_pkg::NUM_RING_PORTS*spidergon_pkg::NUM_VCS-1:0] dequeue_en,
	output wire spidergon_pkg::link_t link_out [spidergon_pkg::NUM_RING_PORTS],
	output wire spidergon_pkg::link_t cpu_out
);
	import spidergon_pkg::*;

	localparam int NUM_CH = NUM_RING_PORTS * NUM_VCS; // channel c is port c/2, vc c%2
	localparam int NUM_OUT = NUM_RING_PORTS + 1; // ring outputs then the local one at STOP

	logic [NUM_OUT-1:0] out_open; // output may take a flit this cycle
	logic [NUM_CH-1:0] out_req [NUM_OUT];
	logic [NUM_CH-1:0] out_grant [NUM_OUT];
	logic [NUM_OUT-1:0] out_valid_q;
	flit_t win_flit [NUM_OUT]; // granted flit, vc already rewritten
	flit_t out_flit_q [NUM_OUT];

	assign out_open = {1'b1, downstream_ready}; // cpu side has no back-pressure

	// each channel asks only the output its route names
	always_comb
	begin
		for (int o = 0; o < NUM_OUT; o++)
		begin
			for (int c = 0; c < NUM_CH; c++)
				out_req[o][c] = request[c] && (route[c] == dir_t'(o)) && out_open[o];
		end
	end

	for (genvar o = 0; o < NUM_OUT; o++)
	begin : g_out
		rr_arbiter #(.WIDTH(NUM_CH)) out_arb_i
		(
			.clk(clk),
			.reset(reset),
			.req(out_req[o]),
			.advance(1'b1), // any grant moves the pointer
			.grant(out_grant[o])
		);
	end

	// a channel routes to one output only, so the grants never overlap
	always_comb
	begin
		dequeue_en = '0;
		for (int o = 0; o < NUM_OUT; o++)
			dequeue_en = dequeue_en | out_grant[o];
	end

	// select the winner and retag it with its local channel index
	always_comb
	begin
		for (int o = 0; o < NUM_OUT; o++)
		begin
			win_flit[o] = head_flit[0];
			for (int c = 0; c < NUM_CH; c++)
			begin
				if (out_grant[o][c])
				begin
					win_flit[o] = head_flit[c];
					win_flit[o].vc = VC_WIDTH'(c % NUM_VCS); // downstream follows this tag
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid_q <= '0;
		else
		begin
			for (int o = 0; o < NUM_OUT; o++)
				out_valid_q[o] <= |out_grant[o]; // one cycle strobe per sent flit
		end
	end

	always_ff @(posedge clk)
	begin
		for (int o = 0; o < NUM_OUT; o++)
		begin
			if (|out_grant[o])
				out_flit_q[o] <= win_flit[o];
		end
	end

	for (genvar r = 0; r < NUM_RING_PORTS; r++)
	begin : g_ring
		assign link_out[r] = '{valid: out_valid_q[r], flit: out_flit_q[r]};
	end

	assign cpu_out = '{valid: out_valid_q[STOP], flit: out_flit_q[STOP]};

endmodule

`default_nettype wire

//--- spidergon_node.sv
// send on link_in only while port_ready is high; output strobes last one cycle, earliest two edges after input
`default_nettype none
`timescale 1ns/10ps

module spidergon_node
#(
	parameter int NODE_ID = 0,
	parameter int NUM_NODES = 8,
	parameter int FIFO_DEPTH = 2
)
(
	input wire clk,
	input wire reset,
	input wire spidergon_pkg::link_t link_in [spidergon_pkg::NUM_RING_PORTS],
	input wire [spidergon_pkg::NUM_RING_PORTS-1:0] downstream_ready,
	output wire spidergon_pkg::link_t link_out [spidergon_pkg::NUM_RING_PORTS],
	output wire [spidergon_pkg::NUM_RING_PORTS-1:0] port_ready,
	output wire spidergon_pkg::link_t cpu_out
);
	import spidergon_pkg::*;

	localparam int NUM_CH = NUM_RING_PORTS * NUM_VCS; // flat channel index port*NUM_VCS + vc

	wire [NUM_CH-1:0] enq_en; // vc allocator to fifo
	wire [NUM_CH-1:0] fifo_full;
	wire [NUM_CH-1:0] fifo_empty;
	wire [NUM_CH-1:0] ch_request; // route ready and flit waiting
	wire [NUM_CH-1:0] deq_en; // switch grant back to fifo and route
	wire flit_t fifo_head [NUM_CH];
	wire dir_t ch_route [NUM_CH];

	for (genvar p = 0; p < NUM_RING_PORTS; p++)
	begin : g_port
		vc_alloc_fsm #(.FIFO_DEPTH(FIFO_DEPTH)) vc_alloc_i
		(
			.clk(clk),
			.reset(reset),
			.link(link_in[p]),
			.fifo_full(fifo_full[p*NUM_VCS +: NUM_VCS]),
			.enqueue_en(enq_en[p*NUM_VCS +: NUM_VCS]),
			.port_ready(port_ready[p])
		);

		for (genvar v = 0; v < NUM_VCS; v++)
		begin : g_vc
			flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i
			(
				.clk(clk),
				.reset(reset),
				.enqueue_en(enq_en[p*NUM_VCS + v]),
				.enqueue_flit(link_in[p].flit), // both channels see the link, only one enqueues
				.dequeue_en(deq_en[p*NUM_VCS + v]),
				.head_flit(fifo_head[p*NUM_VCS + v]),
				.empty(fifo_empty[p*NUM_VCS + v]),
				.full(fifo_full[p*NUM_VCS + v])
			);

			route_compute #(.NODE_ID(NODE_ID), .NUM_NODES(NUM_NODES)) route_i
			(
				.clk(clk),
				.reset(reset),
				.head_flit(fifo_head[p*NUM_VCS + v]),
				.empty(fifo_empty[p*NUM_VCS + v]),
				.dequeue_en(deq_en[p*NUM_VCS + v]),
				.request(ch_request[p*NUM_VCS + v]),
				.route(ch_route[p*NUM_VCS + v])
			);
		end
	end

	switch_alloc switch_i
	(
		.clk(clk),
		.reset(reset),
		.head_flit(fifo_head),
		.request(ch_request),
		.route(ch_route),
		.downstream_ready(downstream_ready),
		.dequeue_en(deq_en),
		.link_out(link_out),
		.cpu_out(cpu_out)
	);

endmodule

`default_nettype wire

//--- tb_spidergon_node.sv
// reads node_cases.txt from the run directory; node 2 of 8, one input flit offered per clock
`default_nettype none
`timescale 1ns/10ps

module tb_spidergon_node;
	import spidergon_pkg::*;

	localparam int NODE_ID = 2;
	localparam int NUM_NODES = 8;
	localparam int FIFO_DEPTH = 2;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_LINE = 200; // watchdog budget per case line
	localparam int MAX_LINES = 64;

	logic clk;
	logic reset;
	link_t link_in [NUM_RING_PORTS];
	logic [NUM_RING_PORTS-1:0] downstream_ready;
	wire link_t link_out [NUM_RING_PORTS];
	wire [NUM_RING_PORTS-1:0] port_ready;
	wire link_t cpu_out;

	int num_lines;
	int line_port [MAX_LINES];
	flit_type_t line_type [MAX_LINES];
	logic [VC_WIDTH-1:0] line_vc [MAX_LINES]; // upstream tag
	logic [FLIT_DATA_WIDTH-1:0] line_data [MAX_LINES];
	int line_dir [MAX_LINES]; // expected output, 3 is the cpu
	int line_pkt [MAX_LINES];
	int line_seq [MAX_LINES]; // position inside its packet
	bit line_done [MAX_LINES];
	int pkt_rcvd [MAX_LINES]; // flits of each packet seen so far
	logic [VC_WIDTH-1:0] pkt_vc [MAX_LINES]; // output vc taken by the first flit
	int rcvd_count;
	bit loaded;
	logic [31:0] lcg_state;
	logic [NUM_RING_PORTS-1:0] ready_at_edge; // downstream_ready as the last rising edge saw it

	spidergon_node #(.NODE_ID(NODE_ID), .NUM_NODES(NUM_NODES), .FIFO_DEPTH(FIFO_DEPTH)) dut_i
	(
		.clk(clk),
		.reset(reset),
		.link_in(link_in),
		.downstream_ready(downstream_ready),
		.link_out(link_out),
		.port_ready(port_ready),
		.cpu_out(cpu_out)
	);

	always #2 clk = ~clk; // 4 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ring distance rule, 0 anticlockwise 1 clockwise 2 across 3 local
	function automatic int spidergon_dir(input int dest);
		int rel;
		rel = (dest - NODE_ID + NUM_NODES) % NUM_NODES;
		if (rel == 0)
			return 3;
		if (rel <= NUM_NODES / 4)
			return 1;
		if (rel >= (3 * NUM_NODES) / 4)
			return 0;
		return 2;
	endfunction

	function automatic string out_name(input int o);
		if (o == NUM_RING_PORTS)
			return "cpu_out";
		return $sformatf("link_out[%0d]", o);
	endfunction

	task automatic stop_on_failure();
		$display("Test FAILED");
		$fatal(1);
	endtask

	// fill the case tables and check the file against the routing rule
	task automatic load_cases();
		int fd;
		int n;
		int port;
		int ftype;
		int vc;
		int dest;
		int src;
		int payload;
		int dir;
		int exp_dir;
		int pkt;
		int num_pkts;
		int open_pkt [NUM_RING_PORTS][NUM_VCS]; // packet open on port and tag, -1 none
		int open_dir [NUM_RING_PORTS][NUM_VCS];
		int pkt_len [MAX_LINES];
		string text;
		num_lines = 0;
		num_pkts = 0;
		for (int p = 0; p < NUM_RING_PORTS; p++)
			for (int v = 0; v < NUM_VCS; v++)
				open_pkt[p][v] = -1;
		fd = $fopen("node_cases.txt", "r");
		assert (fd != 0) else
		begin
			$display("cannot open node_cases.txt");
			stop_on_failure();
		end
		while (!$feof(fd))
		begin
			text = "";
			n = $fgets(text, fd);
			if (n == 0 || text.len() < 2 || text[0] == "#")
				continue; // blank or column notes
			n = $sscanf(text, "%h %h %h %h %h %h %h", port, ftype, vc, dest, src, payload, dir);
			assert (n == 7 && port < NUM_RING_PORTS && vc < NUM_VCS && num_lines < MAX_LINES) else
			begin
				$display("case line %0d is malformed: %s", num_lines, text);
				stop_on_failure();
			end
			line_port[num_lines] = port;
			line_type[num_lines] = flit_type_t'(ftype[1:0]);
			line_vc[num_lines] = VC_WIDTH'(vc);
			line_data[num_lines] = {dest[2:0], src[2:0], payload[9:0]}; // head view packing
			if (ftype == HEAD_FLIT || ftype == HEADER)
			begin
				exp_dir = spidergon_dir(dest); // new packet
				line_pkt[num_lines] = num_pkts;
				line_seq[num_lines] = 0;
				pkt_len[num_pkts] = 1;
				if (ftype == HEAD_FLIT)
				begin
					open_pkt[port][vc] = num_pkts;
					open_dir[port][vc] = exp_dir;
				end
				num_pkts++;
			end
			else
			begin
				assert (open_pkt[port][vc] >= 0) else
				begin
					$display("case line %0d is a body or tail flit outside any packet", num_lines);
					stop_on_failure();
				end
				pkt = open_pkt[port][vc];
				exp_dir = open_dir[port][vc]; // follows its head
				line_pkt[num_lines] = pkt;
				line_seq[num_lines] = pkt_len[pkt];
				pkt_len[pkt]++;
				if (ftype == TAIL_FLIT)
					open_pkt[port][vc] = -1;
			end
			assert (dir == exp_dir) else
			begin
				$display("ERROR case line %0d dir: file %h rule %h", num_lines, dir, exp_dir);
				stop_on_failure();
			end
			line_dir[num_lines] = dir;
			line_done[num_lines] = 1'b0;
			num_lines++;
		end
		$fclose(fd);
		assert (num_lines > 0) else
		begin
			$display("node_cases.txt holds no case lines");
			stop_on_failure();
		end
		for (int i = 0; i < num_pkts; i++)
			pkt_rcvd[i] = 0;
	endtask

	// match one output flit by its unique data and check where and when it left
	task automatic check_output(input int o, input link_t l);
		int found;
		int pkt;
		if (!l.valid)
			return;
		found = -1;
		for (int i = 0; i < num_lines; i++)
		begin
			if (line_data[i] == l.flit.data)
				found = i;
		end
		assert (found >= 0) else
		begin
			$display("%s sent data %h that no case line holds", out_name(o), l.flit.data);
			stop_on_failure();
		end
		assert (!line_done[found]) else
		begin
			$display("%s sent the flit of case line %0d a second time", out_name(o), found);
			stop_on_failure();
		end
		assert (o == line_dir[found]) else
		begin
			$display("ERROR output dir of data %h: got %h expected %h", l.flit.data, o,
				line_dir[found]);
			stop_on_failure();
		end
		assert (l.flit.ftype == line_type[found]) else
		begin
			$display("ERROR %s.flit.ftype: got %h expected %h", out_name(o), l.flit.ftype,
				line_type[found]);
			stop_on_failure();
		end
		pkt = line_pkt[found];
		assert (line_seq[found] == pkt_rcvd[pkt]) else
		begin
			$display("flit of case line %0d left %s ahead of earlier flits of its packet",
				found, out_name(o));
			stop_on_failure();
		end
		if (pkt_rcvd[pkt] == 0)
			pkt_vc[pkt] = l.flit.vc; // packet tag set by its head
		assert (l.flit.vc == pkt_vc[pkt]) else
		begin
			$display("ERROR %s.flit.vc: got %h expected %h", out_name(o), l.flit.vc, pkt_vc[pkt]);
			stop_on_failure();
		end
		line_done[found] = 1'b1;
		pkt_rcvd[pkt]++;
		rcvd_count++;
	endtask

	// next falling edge, links idle, fresh ring back-pressure
	task automatic step_cycle(input bit drain);
		@(negedge clk);
		for (int p = 0; p < NUM_RING_PORTS; p++)
			link_in[p].valid = 1'b0;
		if (drain)
			downstream_ready = '1;
		else
		begin
			lcg_state = lcg_next(lcg_state);
			downstream_ready = lcg_state[30:28]; // upper bits, low ones repeat quickly
		end
	endtask

	// a flit valid now was granted against the ready level of the last rising edge
	always @(posedge clk)
		ready_at_edge <= downstream_ready;

	always @(negedge clk)
	begin
		if (!reset && loaded)
		begin
			for (int r = 0; r < NUM_RING_PORTS; r++)
			begin
				assert (!link_out[r].valid || ready_at_edge[r]) else
				begin
					$display("link_out[%0d] sent a flit while downstream_ready was low", r);
					stop_on_failure();
				end
				check_output(r, link_out[r]);
			end
			check_output(NUM_RING_PORTS, cpu_out);
		end
	end

	// watchdog
	initial
	begin
		wait (loaded);
		repeat (RESET_CYCLES + CYCLES_PER_LINE * num_lines) @(posedge clk);
		$display("run took too long, %0d of %0d flits arrived", rcvd_count, num_lines);
		stop_on_failure();
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		downstream_ready = '0;
		lcg_state = 32'hd5fd6d21;
		rcvd_count = 0;
		loaded = 1'b0;
		for (int p = 0; p < NUM_RING_PORTS; p++)
			link_in[p] = '0;
		load_cases();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < num_lines; i++)
		begin
			step_cycle(1'b0);
			while (!port_ready[line_port[i]])
				step_cycle(1'b0); // hold the line until its port can take it
			link_in[line_port[i]].flit.ftype = line_type[i];
			link_in[line_port[i]].flit.vc = line_vc[i];
			link_in[line_port[i]].flit.data = line_data[i];
			link_in[line_port[i]].valid = 1'b1;
		end
		step_cycle(1'b1);
		while (rcvd_count < num_lines)
			step_cycle(1'b1); // drain with all outputs open
		step_cycle(1'b1);
		step_cycle(1'b1);
		assert (port_ready == '1) else
		begin
			$display("ERROR port_ready: got %h expected %h", port_ready, 3'h7);
			stop_on_failure();
		end
		for (int r = 0; r < NUM_RING_PORTS; r++)
		begin
			assert (!link_out[r].valid) else
			begin
				$display("link_out[%0d] still sends after all flits arrived", r);
				stop_on_failure();
			end
		end
		assert (!cpu_out.valid) else
		begin
			$display("cpu_out still sends after all flits arrived");
			stop_on_failure();
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
spidergon_pkg.sv
flit_fifo.sv
rr_arbiter.sv
vc_alloc_fsm.sv
route_compute.sv
switch_alloc.sv
spidergon_node.sv
tb_spidergon_node.sv

//--- Makefile
# Verilator flow for the spidergon router node
VERILATOR ?= verilator
TOP ?= tb_spidergon_node
RTL_TOP ?= spidergon_node
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
SIM_FLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- node_cases.txt
# port type vc dest src payload dir, all hex; payloads unique so output flits can be matched
# type 1 head 2 body 0 tail 3 header; port and dir 0 anticlockwise 1 clockwise 2 across 3 local
0 1 0 2 1 001 3
0 2 0 0 0 002 3
0 0 0 0 0 003 3
1 1 1 4 3 010 1
1 2 1 0 0 011 1
1 2 1 0 0 012 1
1 0 1 0 0 013 1
0 1 1 6 1 020 2
2 1 0 5 6 030 2
0 2 1 0 0 021 2
2 2 0 0 0 031 2
0 2 1 0 0 022 2
2 2 0 0 0 032 2
0 0 1 0 0 023 2
2 0 0 0 0 033 2
2 3 1 0 6 040 0
2 1 1 1 6 041 0
2 0 1 0 0 042 0
0 3 0 3 1 050 1
0 1 0 7 1 051 2
0 2 0 0 0 052 2
0 0 0 0 0 053 2
1 1 0 2 3 060 3
1 3 1 4 3 061 1
1 2 0 0 0 062 3
1 0 0 0 0 063 3
1 1 0 0 3 070 0
1 0 0 0 0 071 0
